// File: include/icache_cfg.svh
`ifndef ICACHE_CFG_SVH
`define ICACHE_CFG_SVH

// cache geometry, two ways per set
`define ICACHE_SETS       256
`define ICACHE_INDEX_W    8
`define ICACHE_TAG_W      20

// line layout, four 32-bit words
`define ICACHE_LINE_WORDS 4
`define ICACHE_LINE_W     128

`endif

// File: hdl/icache_pkg.sv
`include "icache_cfg.svh"

package icache_pkg;

    // one metadata entry per way and set
    typedef struct packed {
        logic [`ICACHE_TAG_W-1:0] tag;
        logic                     valid;
        logic                     age;   // set when this way is the older one
    } icache_meta_t;

    // lookup into the cache unit
    typedef struct packed {
        logic        read;
        logic [31:0] pc;
    } lookup_req_t;

    // instructions from the offset to the end of the line
    typedef struct packed {
        logic                                valid;
        logic [`ICACHE_LINE_WORDS-1:0][31:0] insts;
        logic [2:0]                          count;  // number of valid words
    } fetch_rsp_t;

    typedef enum logic [2:0] {
        IDLE,
        REQ,
        FILL,
        WRITE,
        REPLAY
    } miss_state_e;

endpackage

// File: hdl/mem_bus_pkg.sv
package mem_bus_pkg;

    typedef enum logic {
        MEM_NOP,
        MEM_READ_LINE
    } mem_cmd_e;

    // line read request, offset bits of addr are zero
    typedef struct packed {
        mem_cmd_e    cmd;
        logic [31:0] addr;
    } mem_req_t;

    // one word beat of a line
    typedef struct packed {
        logic        valid;
        logic [31:0] data;
    } mem_rsp_t;

endpackage

// File: hdl/icache_data_ram.sv
`include "icache_cfg.svh"

module icache_data_ram (
    input  logic                       clk,
    input  logic                       we,
    input  logic [`ICACHE_INDEX_W-1:0] addr,
    input  logic [`ICACHE_LINE_W-1:0]  din,
    output logic [`ICACHE_LINE_W-1:0]  dout
);

    logic [`ICACHE_LINE_W-1:0] mem [`ICACHE_SETS];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= din;
        end
        dout <= mem[addr];  // old content on a write cycle
    end

endmodule

// File: hdl/icache_unit.sv
`include "icache_cfg.svh"

module icache_unit import icache_pkg::*; (
    input  logic                      clk,
    input  logic                      rst,
    input  lookup_req_t               lookup,
    output logic                      hit,
    output logic                      replace_way,
    output fetch_rsp_t                rsp,
    input  logic                      line_wr,
    input  logic                      wr_way,
    input  logic [31:0]               wr_pc,
    input  logic [`ICACHE_LINE_W-1:0] wr_line
);

    localparam int OFF_W  = 32 - `ICACHE_TAG_W - `ICACHE_INDEX_W;
    localparam int WORD_W = $clog2(`ICACHE_LINE_WORDS);

    icache_meta_t meta_way0 [`ICACHE_SETS];
    icache_meta_t meta_way1 [`ICACHE_SETS];

    logic [`ICACHE_INDEX_W-1:0] index;
    logic [`ICACHE_INDEX_W-1:0] wr_index;
    logic [`ICACHE_INDEX_W-1:0] ram_addr;
    logic [`ICACHE_TAG_W-1:0]   tag;
    logic [`ICACHE_TAG_W-1:0]   wr_tag;

    icache_meta_t entry0;
    icache_meta_t entry1;
    logic         hit_way0;
    logic         hit_way1;

    logic [`ICACHE_LINE_W-1:0] ram_dout [2];
    logic [`ICACHE_LINE_W-1:0] line_sel;

    // read stage state, one cycle behind the lookup
    logic              rd_valid_q;
    logic              rd_way_q;
    logic [WORD_W-1:0] word_off_q;

    // address split
    assign index    = lookup.pc[OFF_W +: `ICACHE_INDEX_W];
    assign tag      = lookup.pc[31 -: `ICACHE_TAG_W];
    assign wr_index = wr_pc[OFF_W +: `ICACHE_INDEX_W];
    assign wr_tag   = wr_pc[31 -: `ICACHE_TAG_W];

    assign entry0 = meta_way0[index];
    assign entry1 = meta_way1[index];

    assign hit_way0 = entry0.valid && (entry0.tag == tag);
    assign hit_way1 = entry1.valid && (entry1.tag == tag);
    assign hit      = lookup.read && (hit_way0 || hit_way1);

    // empty way first, way 0 before way 1, else the older one
    always_comb begin
        if (!entry0.valid) begin
            replace_way = 1'b0;
        end else if (!entry1.valid) begin
            replace_way = 1'b1;
        end else begin
            replace_way = (entry0.age >= entry1.age) ? 1'b0 : 1'b1;
        end
    end

    // fill takes the port over the lookup
    assign ram_addr = line_wr ? wr_index : index;

    for (genvar w = 0; w < 2; w++) begin : g_way
        icache_data_ram u_ram (
            .clk  (clk),
            .we   (line_wr && (wr_way == 1'(w))),
            .addr (ram_addr),
            .din  (wr_line),
            .dout (ram_dout[w])
        );
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            rd_valid_q <= 1'b0;
        end else begin
            rd_valid_q <= hit;
        end
    end

    always_ff @(posedge clk) begin
        if (hit) begin
            rd_way_q   <= hit_way1;
            word_off_q <= lookup.pc[2 +: WORD_W];
        end
    end

    assign line_sel = ram_dout[rd_way_q];

    // shift the line down to the word offset, zero fill the top
    always_comb begin
        rsp.valid = rd_valid_q;
        rsp.count = 3'(`ICACHE_LINE_WORDS - word_off_q);
        for (int i = 0; i < `ICACHE_LINE_WORDS; i++) begin
            if (i + word_off_q < `ICACHE_LINE_WORDS) begin
                rsp.insts[i] = line_sel[(i + word_off_q) * 32 +: 32];
            end else begin
                rsp.insts[i] = '0;
            end
        end
    end

    // tags, valid bits and ages
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int s = 0; s < `ICACHE_SETS; s++) begin
                meta_way0[s] <= '0;
                meta_way1[s] <= '0;
            end
        end else begin
            if (hit) begin
                meta_way0[index].age <= hit_way1;  // hit way becomes the newer
                meta_way1[index].age <= hit_way0;
            end
            if (line_wr) begin
                // written way is newer, the other one ages
                if (wr_way) begin
                    meta_way1[wr_index]     <= '{tag: wr_tag, valid: 1'b1, age: 1'b0};
                    meta_way0[wr_index].age <= 1'b1;
                end else begin
                    meta_way0[wr_index]     <= '{tag: wr_tag, valid: 1'b1, age: 1'b0};
                    meta_way1[wr_index].age <= 1'b1;
                end
            end
        end
    end

endmodule

// File: hdl/icache_miss_ctrl.sv
`include "icache_cfg.svh"

module icache_miss_ctrl import icache_pkg::*, mem_bus_pkg::*; (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      fetch_req,
    input  logic [31:0]               fetch_pc,
    input  logic                      hit,
    input  logic                      replace_way,
    output lookup_req_t               lookup,
    output logic                      busy,
    output mem_req_t                  mem_req,
    input  mem_rsp_t                  mem_rsp,
    output logic                      line_wr,
    output logic                      wr_way,
    output logic [31:0]               wr_pc,
    output logic [`ICACHE_LINE_W-1:0] wr_line
);

    localparam int OFF_W  = 32 - `ICACHE_TAG_W - `ICACHE_INDEX_W;
    localparam int WORD_W = $clog2(`ICACHE_LINE_WORDS);

    miss_state_e state;
    miss_state_e state_nxt;

    logic                      miss_start;
    logic                      last_beat;
    logic [WORD_W-1:0]         beat_cnt;
    logic [31:0]               miss_pc;
    logic                      miss_way;
    logic [`ICACHE_LINE_W-1:0] line_buf;

    assign miss_start = (state == IDLE) && fetch_req && !hit;
    assign last_beat  = (state == FILL) && mem_rsp.valid
                        && (beat_cnt == WORD_W'(`ICACHE_LINE_WORDS - 1));

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:    if (miss_start) state_nxt = REQ;
            REQ:     state_nxt = FILL;
            FILL:    if (last_beat) state_nxt = WRITE;
            WRITE:   state_nxt = REPLAY;
            REPLAY:  state_nxt = IDLE;   // replay hits, response comes next cycle
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state    <= IDLE;
            beat_cnt <= '0;
        end else begin
            state <= state_nxt;
            if (state == REQ) begin
                beat_cnt <= '0;
            end else if (state == FILL && mem_rsp.valid) begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (miss_start) begin
            miss_pc  <= fetch_pc;
            miss_way <= replace_way;
        end
        // word 0 arrives first and ends up in the low bits
        if (state == FILL && mem_rsp.valid) begin
            line_buf <= {mem_rsp.data, line_buf[`ICACHE_LINE_W-1:32]};
        end
    end

    // lookup source, fetch port while idle, saved pc on replay
    always_comb begin
        lookup.read = 1'b0;
        lookup.pc   = fetch_pc;
        if (state == IDLE) begin
            lookup.read = fetch_req;
        end else if (state == REPLAY) begin
            lookup.read = 1'b1;
            lookup.pc   = miss_pc;
        end
    end

    assign busy = (state != IDLE);

    assign mem_req.cmd  = (state == REQ) ? MEM_READ_LINE : MEM_NOP;
    assign mem_req.addr = {miss_pc[31:OFF_W], OFF_W'(0)};  // line aligned

    assign line_wr = (state == WRITE);
    assign wr_way  = miss_way;
    assign wr_pc   = miss_pc;
    assign wr_line = line_buf;

endmodule

// File: hdl/icache_top.sv
`include "icache_cfg.svh"

module icache_top import icache_pkg::*, mem_bus_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        fetch_req,
    input  logic [31:0] fetch_pc,
    output logic        busy,
    output fetch_rsp_t  fetch_rsp,
    output mem_req_t    mem_req,
    input  mem_rsp_t    mem_rsp
);

    lookup_req_t               lookup;
    logic                      hit;
    logic                      replace_way;

    // line fill path from the controller
    logic                      line_wr;
    logic                      wr_way;
    logic [31:0]               wr_pc;
    logic [`ICACHE_LINE_W-1:0] wr_line;

    icache_miss_ctrl u_miss_ctrl (
        .clk         (clk),
        .rst         (rst),
        .fetch_req   (fetch_req),
        .fetch_pc    (fetch_pc),
        .hit         (hit),
        .replace_way (replace_way),
        .lookup      (lookup),
        .busy        (busy),
        .mem_req     (mem_req),
        .mem_rsp     (mem_rsp),
        .line_wr     (line_wr),
        .wr_way      (wr_way),
        .wr_pc       (wr_pc),
        .wr_line     (wr_line)
    );

    icache_unit u_unit (
        .clk         (clk),
        .rst         (rst),
        .lookup      (lookup),
        .hit         (hit),
        .replace_way (replace_way),
        .rsp         (fetch_rsp),
        .line_wr     (line_wr),
        .wr_way      (wr_way),
        .wr_pc       (wr_pc),
        .wr_line     (wr_line)
    );

endmodule

// File: testbench/icache_assertions.sv
module icache_assertions import mem_bus_pkg::*; (
    input logic     clk,
    input logic     rst,
    input logic     fetch_req,
    input logic     busy,
    input mem_req_t mem_req,
    input mem_rsp_t mem_rsp,
    input logic     line_wr
);

    timeunit 1ns;
    timeprecision 100ps;

    logic [2:0] beats_seen;  // beats since the last line read

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            beats_seen <= '0;
        end else if (mem_req.cmd == MEM_READ_LINE) begin
            beats_seen <= '0;
        end else if (mem_rsp.valid && beats_seen != 3'd4) begin
            beats_seen <= beats_seen + 1'b1;
        end
    end

    a_req_single: assert property (@(posedge clk) disable iff (!rst)
        mem_req.cmd == MEM_READ_LINE |=> mem_req.cmd == MEM_NOP)
        else $error("line read request held for more than one cycle");

    a_write_after_fill: assert property (@(posedge clk) disable iff (!rst)
        line_wr |-> beats_seen == 3'd4)
        else $error("line written before four beats arrived");

    // controller comes out of reset idle
    a_idle_after_reset: assert property (@(posedge clk)
        $rose(rst) |-> !busy && mem_req.cmd == MEM_NOP)
        else $error("controller not idle after reset");

    a_no_fetch_while_busy: assert property (@(posedge clk) disable iff (!rst)
        busy |-> !fetch_req)
        else $error("fetch request raised while busy");

endmodule

bind icache_miss_ctrl icache_assertions u_assertions (
    .clk       (clk),
    .rst       (rst),
    .fetch_req (fetch_req),
    .busy      (busy),
    .mem_req   (mem_req),
    .mem_rsp   (mem_rsp),
    .line_wr   (line_wr)
);

// File: testbench/icache_tb.sv
`include "icache_cfg.svh"

module icache_tb import icache_pkg::*, mem_bus_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_FETCHES  = 600;
    localparam int MISS_TIMEOUT = 100;
    localparam int MAX_CYCLES   = 20000;
    localparam logic [`ICACHE_TAG_W-1:0]   TAG_POOL [3] = '{20'h00012, 20'h0a5c3, 20'h7f001};
    localparam logic [`ICACHE_INDEX_W-1:0] IDX_POOL [4] = '{8'h00, 8'h01, 8'h80, 8'hff};

    logic        clk;
    logic        rst;
    logic        fetch_req;
    logic [31:0] fetch_pc;
    logic        busy;
    fetch_rsp_t  fetch_rsp;
    mem_req_t    mem_req;
    mem_rsp_t    mem_rsp;

    integer      seed;
    logic [31:0] rnd;
    int          cycle;
    int          issued;
    int          num_hits;
    int          num_evicts;

    // reference cache, age 1 marks the older way
    logic [`ICACHE_TAG_W-1:0] model_tag   [2][`ICACHE_SETS];
    logic                     model_valid [2][`ICACHE_SETS];
    logic                     model_age   [2][`ICACHE_SETS];

    // expected responses in issue order
    logic [`ICACHE_LINE_W-1:0] exp_insts_q [$];
    logic [2:0]                exp_count_q [$];
    int                        exp_cycle_q [$];  // -1 for a miss

    logic        miss_pending;
    logic        miss_req_seen;
    logic        miss_way;
    logic [31:0] miss_line;
    int          miss_age;

    // memory responder state
    logic [31:0] mem_line;
    int          beats_left;
    int          beat;
    int          gap_left;

    icache_top dut (
        .clk       (clk),
        .rst       (rst),
        .fetch_req (fetch_req),
        .fetch_pc  (fetch_pc),
        .busy      (busy),
        .fetch_rsp (fetch_rsp),
        .mem_req   (mem_req),
        .mem_rsp   (mem_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        return addr ^ {addr[15:0], addr[31:16]} ^ 32'h9e37_79b9;
    endfunction

    // words from the offset to the end of the line, zero above
    function automatic logic [`ICACHE_LINE_W-1:0] expected_insts(input logic [31:0] pc);
        logic [`ICACHE_LINE_W-1:0] insts;
        logic [31:0]               base;
        int                        off;
        insts = '0;
        base  = {pc[31:4], 4'h0};
        off   = int'(pc[3:2]);
        for (int i = 0; i < `ICACHE_LINE_WORDS; i++) begin
            if (i + off < `ICACHE_LINE_WORDS) begin
                insts[i*32 +: 32] = mem_word(base + 32'(4 * (i + off)));
            end
        end
        return insts;
    endfunction

    task automatic abort_run(input string what);
        $display("ERROR at %0t: %s", $time, what);
        $display("TESTBENCH FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic compare_value(input string name, input logic [127:0] expected,
                                 input logic [127:0] actual);
        if (expected !== actual) begin
            $display("FAIL time=%0t %s expected=%h actual=%h", $time, name, expected, actual);
            $display("TESTBENCH FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic model_access(input logic [31:0] pc, output logic hit, output logic way);
        logic [`ICACHE_INDEX_W-1:0] idx;
        logic [`ICACHE_TAG_W-1:0]   tg;
        idx = pc[4 +: `ICACHE_INDEX_W];
        tg  = pc[31 -: `ICACHE_TAG_W];
        hit = 1'b1;
        if (model_valid[0][idx] && model_tag[0][idx] == tg) begin
            way = 1'b0;
        end else if (model_valid[1][idx] && model_tag[1][idx] == tg) begin
            way = 1'b1;
        end else begin
            hit = 1'b0;
            if (!model_valid[0][idx]) begin
                way = 1'b0;
            end else if (!model_valid[1][idx]) begin
                way = 1'b1;
            end else begin
                way = model_age[0][idx] ? 1'b0 : 1'b1;  // evict the older way
                num_evicts++;
            end
            model_tag[way][idx]   = tg;
            model_valid[way][idx] = 1'b1;
        end
        model_age[way][idx]  = 1'b0;
        model_age[~way][idx] = 1'b1;
    endtask

    task automatic check_outputs();
        logic [`ICACHE_LINE_W-1:0] exp_insts;
        logic [2:0]                exp_count;
        int                        exp_cycle;
        if (miss_pending) miss_age++;
        if (miss_age > MISS_TIMEOUT) abort_run("no response to a cache miss in time");
        if (mem_req.cmd == MEM_READ_LINE) begin
            if (!miss_pending || miss_req_seen) abort_run("memory read without a new miss");
            miss_req_seen = 1'b1;
            compare_value("mem_req.cmd cycles after miss", 128'(1), 128'(miss_age));
            compare_value("mem_req.addr", 128'(miss_line), 128'(mem_req.addr));
            compare_value("replace_way", 128'(miss_way), 128'(dut.u_miss_ctrl.miss_way));
        end
        if (fetch_rsp.valid) begin
            if (exp_cycle_q.size() == 0) abort_run("fetch response with no fetch outstanding");
            exp_insts = exp_insts_q.pop_front();
            exp_count = exp_count_q.pop_front();
            exp_cycle = exp_cycle_q.pop_front();
            compare_value("fetch_rsp.insts", exp_insts, fetch_rsp.insts);
            compare_value("fetch_rsp.count", 128'(exp_count), 128'(fetch_rsp.count));
            if (exp_cycle >= 0) begin
                compare_value("hit response cycle", 128'(exp_cycle), 128'(cycle));
            end else begin
                compare_value("busy", 128'(1'b0), 128'(busy));  // drops with the response
                compare_value("line reads per miss", 128'(1'b1), 128'(miss_req_seen));
                miss_pending = 1'b0;
            end
        end else begin
            compare_value("busy", 128'(miss_pending), 128'(busy));  // high only during a miss
        end
        if (exp_cycle_q.size() != 0 && exp_cycle_q[0] >= 0 && exp_cycle_q[0] < cycle) begin
            abort_run("hit response did not arrive one cycle after the fetch");
        end
    endtask

    // four beats per line read, 0 to 3 idle cycles before each
    task automatic respond_memory();
        if (beats_left == 0) begin
            mem_rsp = '0;
            if (mem_req.cmd == MEM_READ_LINE) begin
                mem_line   = mem_req.addr;
                beats_left = `ICACHE_LINE_WORDS;
                beat       = 0;
                rnd        = $random(seed);
                gap_left   = int'(rnd[1:0]);
            end
        end else if (gap_left > 0) begin
            mem_rsp.valid = 1'b0;
            gap_left--;
        end else begin
            mem_rsp.valid = 1'b1;
            mem_rsp.data  = mem_word(mem_line + 32'(4 * beat));
            beat++;
            beats_left--;
            rnd      = $random(seed);
            gap_left = int'(rnd[1:0]);
        end
    endtask

    task automatic drive_fetch();
        logic hit;
        logic way;
        rnd       = $random(seed);
        fetch_req = 1'b0;
        if (!busy && issued < NUM_FETCHES && rnd[15:14] != 2'b00) begin
            fetch_pc  = {TAG_POOL[int'(rnd[7:0]) % 3], IDX_POOL[rnd[9:8]], rnd[11:10], 2'b00};
            fetch_req = 1'b1;
            issued++;
            model_access(fetch_pc, hit, way);
            exp_insts_q.push_back(expected_insts(fetch_pc));
            exp_count_q.push_back(3'(`ICACHE_LINE_WORDS - int'(fetch_pc[3:2])));
            if (hit) begin
                num_hits++;
                exp_cycle_q.push_back(cycle + 1);
            end else begin
                exp_cycle_q.push_back(-1);
                miss_pending  = 1'b1;
                miss_req_seen = 1'b0;
                miss_way      = way;
                miss_line     = {fetch_pc[31:4], 4'h0};
                miss_age      = 0;
            end
        end
    endtask

    initial begin
        seed          = 32'h7571;
        rst           = 1'b0;
        fetch_req     = 1'b0;
        fetch_pc      = '0;
        mem_rsp       = '0;
        cycle         = 0;
        issued        = 0;
        num_hits      = 0;
        num_evicts    = 0;
        miss_pending  = 1'b0;
        miss_req_seen = 1'b0;
        miss_way      = 1'b0;
        miss_line     = '0;
        miss_age      = 0;
        mem_line      = '0;
        beats_left    = 0;
        beat          = 0;
        gap_left      = 0;
        for (int s = 0; s < `ICACHE_SETS; s++) begin
            for (int w = 0; w < 2; w++) begin
                model_tag[w][s]   = '0;
                model_valid[w][s] = 1'b0;
                model_age[w][s]   = 1'b0;
            end
        end
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;
        @(negedge clk);
        compare_value("busy", 128'(1'b0), 128'(busy));
        compare_value("mem_req.cmd", 128'(MEM_NOP), 128'(mem_req.cmd));
        compare_value("fetch_rsp.valid", 128'(1'b0), 128'(fetch_rsp.valid));
        while (issued < NUM_FETCHES || exp_cycle_q.size() != 0) begin
            @(negedge clk);
            cycle++;
            if (cycle > MAX_CYCLES) abort_run("run did not finish within the cycle limit");
            check_outputs();
            respond_memory();
            drive_fetch();
        end
        if (num_hits == 0 || num_evicts == 0) begin
            abort_run("random fetches produced no hits or no evictions");
        end else begin
            $display("%0d fetches, %0d hits, %0d evictions", issued, num_hits, num_evicts);
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

endmodule

// File: compile.f
+incdir+include
hdl/icache_pkg.sv
hdl/mem_bus_pkg.sv
hdl/icache_data_ram.sv
hdl/icache_unit.sv
hdl/icache_miss_ctrl.sv
hdl/icache_top.sv
testbench/icache_assertions.sv
testbench/icache_tb.sv

// File: Makefile
TOP = icache_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f compile.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f compile.f -o icache_sim
	./obj_dir/icache_sim > sim.log 2>&1 || true
	cat sim.log
	grep -q "TESTBENCH PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
